// ==== hdl/glb_cfg_pkg.sv ====
/*
 * shared widths, address layout and request/response structs of the config chain
 * imported by every module of the global buffer config network
 */
package glb_cfg_pkg;

    // configuration data word and request address
    localparam int CFG_DATA_WIDTH = 32;
    localparam int CFG_ADDR_WIDTH = 16;

    // byte offset bits below the register field, ignored by decode
    localparam int CFG_BYTE_OFFSET = 2;

    // tile select sits directly above the register field
    localparam int TILE_SEL_WIDTH = 4;

    // request travelling west to east
    // clock enables are levels, wr_en and rd_en are one-cycle strobes
    typedef struct packed {
        logic                      wr_clk_en;
        logic                      wr_en;
        logic [CFG_ADDR_WIDTH-1:0] wr_addr;
        logic [CFG_DATA_WIDTH-1:0] wr_data;
        logic                      rd_clk_en;
        logic                      rd_en;
        logic [CFG_ADDR_WIDTH-1:0] rd_addr;
    } cfg_req_t;

    // read response travelling east to west
    // rd_data is qualified by the one-cycle valid strobe
    typedef struct packed {
        logic                      rd_data_valid;
        logic [CFG_DATA_WIDTH-1:0] rd_data;
    } cfg_rsp_t;

endpackage

// ==== hdl/glb_tile_cfg_regs.sv ====
/*
 * per-tile register block with NUM_REGS read/write registers
 * reads take two cycles and end in ack with data or nack with zero
 */
`timescale 1ns/1ps

module glb_tile_cfg_regs #(
    parameter int REG_ADDR_WIDTH = 6,
    parameter int NUM_REGS       = 8
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     pio_write,
    input  logic                                     pio_read,
    input  logic [REG_ADDR_WIDTH-1:0]                pio_address,
    input  logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0]   pio_write_data,
    output logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0]   pio_read_data,
    output logic                                     pio_ack,
    output logic                                     pio_nack
);
    import glb_cfg_pkg::*;

    localparam int IDX_WIDTH = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

    logic [CFG_DATA_WIDTH-1:0] regs [NUM_REGS];
    logic [IDX_WIDTH-1:0]      reg_idx;
    logic                      addr_hit;

    // first read stage
    logic                      rd_valid_s1;
    logic                      rd_hit_s1;
    logic [CFG_DATA_WIDTH-1:0] rd_data_s1;

    assign reg_idx  = pio_address[IDX_WIDTH-1:0];
    // extra msb keeps NUM_REGS == 2**REG_ADDR_WIDTH from wrapping
    assign addr_hit = ({1'b0, pio_address} < (REG_ADDR_WIDTH + 1)'(NUM_REGS));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (pio_write && addr_hit) begin
            regs[reg_idx] <= pio_write_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid_s1 <= 1'b0;
            pio_ack     <= 1'b0;
            pio_nack    <= 1'b0;
        end else begin
            rd_valid_s1 <= pio_read;
            pio_ack     <= rd_valid_s1 & rd_hit_s1;
            pio_nack    <= rd_valid_s1 & ~rd_hit_s1;
        end
    end

    // data path of the read pipeline, zeroed on a miss in the first stage
    always_ff @(posedge clk) begin
        if (pio_read) begin
            rd_hit_s1  <= addr_hit;
            rd_data_s1 <= addr_hit ? regs[reg_idx] : '0;
        end
        if (rd_valid_s1) begin
            pio_read_data <= rd_data_s1;
        end
    end

    // the router resolves read/write collisions before they get here
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
        !(pio_read && pio_write))
        else $error("register block sees read and write together");

endmodule

// ==== hdl/glb_tile_cfg_ctrl.sv ====
/*
 * per-tile config router: decodes requests for this tile into register strobes,
 * forwards all other requests one tile east and merges read responses westward
 */
`timescale 1ns/1ps

module glb_tile_cfg_ctrl #(
    parameter int TILE_ID        = 0,
    parameter int REG_ADDR_WIDTH = 6
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  glb_cfg_pkg::cfg_req_t                    cfg_wst_req,
    output glb_cfg_pkg::cfg_req_t                    cfg_est_req,
    input  glb_cfg_pkg::cfg_rsp_t                    cfg_est_rsp,
    output glb_cfg_pkg::cfg_rsp_t                    cfg_wst_rsp,
    output logic                                     pio_write,
    output logic                                     pio_read,
    output logic [REG_ADDR_WIDTH-1:0]                pio_address,
    output logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0]   pio_write_data,
    input  logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0]   pio_read_data,
    input  logic                                     pio_ack,
    input  logic                                     pio_nack
);
    import glb_cfg_pkg::*;

    localparam int SEL_LSB = REG_ADDR_WIDTH + CFG_BYTE_OFFSET;
    localparam logic [TILE_SEL_WIDTH-1:0] TILE_SEL = TILE_SEL_WIDTH'(TILE_ID);

    logic wr_match;
    logic rd_match;
    logic rd_en_d1;
    logic rd_en_d2;
    cfg_rsp_t local_rsp;

    // forwarded request, strobes and enables under reset, payload without
    logic                      est_wr_clk_en;
    logic                      est_wr_en;
    logic [CFG_ADDR_WIDTH-1:0] est_wr_addr;
    logic [CFG_DATA_WIDTH-1:0] est_wr_data;
    logic                      est_rd_clk_en;
    logic                      est_rd_en;
    logic [CFG_ADDR_WIDTH-1:0] est_rd_addr;

    assign wr_match = (cfg_wst_req.wr_addr[SEL_LSB +: TILE_SEL_WIDTH] == TILE_SEL);
    assign rd_match = (cfg_wst_req.rd_addr[SEL_LSB +: TILE_SEL_WIDTH] == TILE_SEL);

    // local decode, a write to this tile drops a read in the same cycle
    assign pio_write      = cfg_wst_req.wr_en & wr_match;
    assign pio_read       = cfg_wst_req.rd_en & rd_match & ~pio_write;
    assign pio_write_data = cfg_wst_req.wr_data;
    assign pio_address    = pio_write ? cfg_wst_req.wr_addr[CFG_BYTE_OFFSET +: REG_ADDR_WIDTH]
                                      : cfg_wst_req.rd_addr[CFG_BYTE_OFFSET +: REG_ADDR_WIDTH];

    // read strobe delayed to line up with ack/nack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_en_d1 <= 1'b0;
            rd_en_d2 <= 1'b0;
        end else begin
            rd_en_d1 <= pio_read;
            rd_en_d2 <= rd_en_d1;
        end
    end

    // local response, data zeroed when idle so the west merge stays clean
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            local_rsp <= '0;
        end else begin
            local_rsp.rd_data_valid <= rd_en_d2 & (pio_ack | pio_nack);
            local_rsp.rd_data       <= (rd_en_d2 & (pio_ack | pio_nack)) ? pio_read_data : '0;
        end
    end

    // strobes go east only under the incoming clock enable
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            est_wr_en <= 1'b0;
            est_rd_en <= 1'b0;
        end else begin
            est_wr_en <= cfg_wst_req.wr_clk_en & cfg_wst_req.wr_en & ~wr_match;
            est_rd_en <= cfg_wst_req.rd_clk_en & cfg_wst_req.rd_en & ~rd_match;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_wst_req.wr_clk_en && cfg_wst_req.wr_en && !wr_match) begin
            est_wr_addr <= cfg_wst_req.wr_addr;
            est_wr_data <= cfg_wst_req.wr_data;
        end
        if (cfg_wst_req.rd_clk_en && cfg_wst_req.rd_en && !rd_match) begin
            est_rd_addr <= cfg_wst_req.rd_addr;
        end
    end

    // enables copied on the falling edge so the next tile sees them this cycle
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            est_wr_clk_en <= 1'b0;
            est_rd_clk_en <= 1'b0;
        end else begin
            est_wr_clk_en <= cfg_wst_req.wr_clk_en;
            est_rd_clk_en <= cfg_wst_req.rd_clk_en;
        end
    end

    always_comb begin
        cfg_est_req = '{
            wr_clk_en: est_wr_clk_en,
            wr_en:     est_wr_en,
            wr_addr:   est_wr_addr,
            wr_data:   est_wr_data,
            rd_clk_en: est_rd_clk_en,
            rd_en:     est_rd_en,
            rd_addr:   est_rd_addr
        };
    end

    // own response wins over traffic from the east
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_wst_rsp <= '0;
        end else begin
            cfg_wst_rsp <= local_rsp.rd_data_valid ? local_rsp : cfg_est_rsp;
        end
    end

    // reads must be spaced so a tile never has two responses to merge
    a_rsp_collision: assert property (@(posedge clk) disable iff (reset)
        !(local_rsp.rd_data_valid && cfg_est_rsp.rd_data_valid))
        else $error("tile %0d: local and east read responses collide", TILE_ID);

    // ack and nack from the register block are exclusive
    a_ack_nack_excl: assert property (@(posedge clk) disable iff (reset)
        !(pio_ack && pio_nack))
        else $error("tile %0d: register block raises ack and nack together", TILE_ID);

endmodule

// ==== hdl/glb_tile.sv ====
/*
 * one global buffer tile on the config chain
 * joins the config router to its local register block
 */
`timescale 1ns/1ps

module glb_tile #(
    parameter int TILE_ID        = 0,
    parameter int REG_ADDR_WIDTH = 6,
    parameter int NUM_REGS       = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  glb_cfg_pkg::cfg_req_t cfg_wst_req,
    output glb_cfg_pkg::cfg_req_t cfg_est_req,
    input  glb_cfg_pkg::cfg_rsp_t cfg_est_rsp,
    output glb_cfg_pkg::cfg_rsp_t cfg_wst_rsp
);
    import glb_cfg_pkg::*;

    // router to register block
    logic                      pio_write;
    logic                      pio_read;
    logic [REG_ADDR_WIDTH-1:0] pio_address;
    logic [CFG_DATA_WIDTH-1:0] pio_write_data;
    logic [CFG_DATA_WIDTH-1:0] pio_read_data;
    logic                      pio_ack;
    logic                      pio_nack;

    glb_tile_cfg_ctrl #(
        .TILE_ID        (TILE_ID),
        .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
    ) u_cfg_ctrl (
        .clk            (clk),
        .reset          (reset),
        .cfg_wst_req    (cfg_wst_req),
        .cfg_est_req    (cfg_est_req),
        .cfg_est_rsp    (cfg_est_rsp),
        .cfg_wst_rsp    (cfg_wst_rsp),
        .pio_write      (pio_write),
        .pio_read       (pio_read),
        .pio_address    (pio_address),
        .pio_write_data (pio_write_data),
        .pio_read_data  (pio_read_data),
        .pio_ack        (pio_ack),
        .pio_nack       (pio_nack)
    );

    glb_tile_cfg_regs #(
        .REG_ADDR_WIDTH (REG_ADDR_WIDTH),
        .NUM_REGS       (NUM_REGS)
    ) u_cfg_regs (
        .clk            (clk),
        .reset          (reset),
        .pio_write      (pio_write),
        .pio_read       (pio_read),
        .pio_address    (pio_address),
        .pio_write_data (pio_write_data),
        .pio_read_data  (pio_read_data),
        .pio_ack        (pio_ack),
        .pio_nack       (pio_nack)
    );

endmodule

// ==== hdl/glb_cfg_chain.sv ====
/*
 * top of the config network: NUM_TILES tiles chained west to east
 * requests enter at tile 0 and read responses leave from tile 0
 */
`timescale 1ns/1ps

module glb_cfg_chain #(
    parameter int NUM_TILES      = 4,
    parameter int REG_ADDR_WIDTH = 6,
    parameter int NUM_REGS       = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  glb_cfg_pkg::cfg_req_t cfg_req,
    output glb_cfg_pkg::cfg_rsp_t cfg_rsp
);
    import glb_cfg_pkg::*;

    // entry k is the west side of tile k
    // the last request entry is the east edge where stray requests end
    cfg_req_t req_chain [NUM_TILES+1];
    cfg_rsp_t rsp_chain [NUM_TILES+1];

    // register and tile fields must fit in the address
    if (REG_ADDR_WIDTH + CFG_BYTE_OFFSET + TILE_SEL_WIDTH > CFG_ADDR_WIDTH) begin : g_bad_addr
        $error("address layout exceeds CFG_ADDR_WIDTH");
    end

    if (NUM_REGS > (1 << REG_ADDR_WIDTH)) begin : g_bad_regs
        $error("NUM_REGS does not fit in the register field");
    end

    assign req_chain[0]         = cfg_req;
    assign rsp_chain[NUM_TILES] = '0;
    assign cfg_rsp              = rsp_chain[0];

    for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
        glb_tile #(
            .TILE_ID        (k),
            .REG_ADDR_WIDTH (REG_ADDR_WIDTH),
            .NUM_REGS       (NUM_REGS)
        ) u_tile (
            .clk         (clk),
            .reset       (reset),
            .cfg_wst_req (req_chain[k]),
            .cfg_est_req (req_chain[k+1]),
            .cfg_est_rsp (rsp_chain[k+1]),
            .cfg_wst_rsp (rsp_chain[k])
        );
    end

endmodule

// ==== tests/glb_cfg_chain_tb.sv ====
/*
 * directed testbench of the config chain: reset state, read-back latency,
 * unmapped registers, clock enables, write priority and random traffic
 */
`timescale 1ns/1ps

module glb_cfg_chain_tb;
    import glb_cfg_pkg::*;

    localparam int NUM_TILES      = 4;
    localparam int REG_ADDR_WIDTH = 6;
    localparam int NUM_REGS       = 8;
    localparam int TILE_BITS      = $clog2(NUM_TILES);
    localparam int REG_BITS       = $clog2(NUM_REGS);
    localparam int MAX_CYCLES     = 2000;

    logic     clk;
    logic     reset;
    cfg_req_t req;
    cfg_rsp_t rsp;

    // expected register contents per tile
    logic [CFG_DATA_WIDTH-1:0] model [NUM_TILES][NUM_REGS];

    int     errors;
    int     checks;
    int     cycles;
    integer seed;

    glb_cfg_chain #(
        .NUM_TILES      (NUM_TILES),
        .REG_ADDR_WIDTH (REG_ADDR_WIDTH),
        .NUM_REGS       (NUM_REGS)
    ) dut0 (
        .clk     (clk),
        .reset   (reset),
        .cfg_req (req),
        .cfg_rsp (rsp)
    );

    always #50 clk = ~clk;

    // run limit in clock cycles
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles before the tests completed", cycles);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // address layout is {tile select, register, byte offset}
    function automatic logic [CFG_ADDR_WIDTH-1:0] cfg_addr(input int tile, input int reg_num);
        logic [CFG_ADDR_WIDTH-1:0] addr;
        addr = '0;
        addr[CFG_BYTE_OFFSET +: REG_ADDR_WIDTH] = reg_num[REG_ADDR_WIDTH-1:0];
        addr[CFG_BYTE_OFFSET + REG_ADDR_WIDTH +: TILE_SEL_WIDTH] = tile[TILE_SEL_WIDTH-1:0];
        return addr;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // one request cycle, then watch cfg_rsp until every effect has settled
    task automatic access(input logic do_wr, input int wr_tile, input int wr_reg,
                          input logic [CFG_DATA_WIDTH-1:0] wr_data, input logic do_rd,
                          input int rd_tile, input int rd_reg);
        logic                      exp_valid;
        logic [CFG_DATA_WIDTH-1:0] exp_data;
        int                        latency;
        int                        window;
        exp_valid = do_rd && rd_tile < NUM_TILES && !(do_wr && wr_tile == rd_tile)
                    && (rd_tile == 0 || req.rd_clk_en);
        exp_data = '0;
        if (exp_valid && rd_reg < NUM_REGS) begin
            exp_data = model[rd_tile[TILE_BITS-1:0]][rd_reg[REG_BITS-1:0]];
        end
        latency = 2 * rd_tile + 4;
        window  = NUM_TILES + 2;
        if (do_rd && latency + 2 > window) begin
            window = latency + 2;
        end
        if (do_rd && !exp_valid) begin
            window = 12;
        end
        req.wr_en   = do_wr;
        req.wr_addr = cfg_addr(wr_tile, wr_reg);
        req.wr_data = wr_data;
        req.rd_en   = do_rd;
        req.rd_addr = cfg_addr(rd_tile, rd_reg);
        for (int n = 1; n <= window; n++) begin
            next_cycle();
            if (n == 1) begin
                req.wr_en = 1'b0;
                req.rd_en = 1'b0;
            end
            checks++;
            if (exp_valid && n == latency) begin
                if (rsp.rd_data_valid !== 1'b1) begin
                    $display("Mismatch: cfg_rsp.rd_data_valid at cycle %0d: expected %h, got %h",
                             n, 1'b1, rsp.rd_data_valid);
                    errors++;
                end else if (rsp.rd_data !== exp_data) begin
                    $display("Mismatch: cfg_rsp.rd_data tile %0d reg %0d: expected %h, got %h",
                             rd_tile, rd_reg, exp_data, rsp.rd_data);
                    errors++;
                end
            end else if (rsp.rd_data_valid !== 1'b0) begin
                $display("Mismatch: cfg_rsp.rd_data_valid at cycle %0d: expected %h, got %h",
                         n, 1'b0, rsp.rd_data_valid);
                errors++;
            end
        end
        // tile 0 decodes regardless of the enable, further tiles need it
        if (do_wr && wr_tile < NUM_TILES && wr_reg < NUM_REGS
            && (wr_tile == 0 || req.wr_clk_en)) begin
            model[wr_tile[TILE_BITS-1:0]][wr_reg[REG_BITS-1:0]] = wr_data;
        end
    endtask

    task automatic write_reg(input int tile, input int reg_num, input logic [31:0] data);
        access(1'b1, tile, reg_num, data, 1'b0, 0, 0);
    endtask

    task automatic read_reg(input int tile, input int reg_num);
        access(1'b0, 0, 0, '0, 1'b1, tile, reg_num);
    endtask

    task automatic check_reset_state();
        checks++;
        if (rsp !== '0) begin
            $display("Mismatch: cfg_rsp after reset: expected %h, got %h", 33'h0, rsp);
            errors++;
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                read_reg(t, r);
            end
        end
    endtask

    task automatic write_read_back();
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                write_reg(t, r, 32'h5a00_0000 ^ (t << 12) ^ (r << 4) ^ 32'h9);
            end
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                read_reg(t, r);
            end
        end
    endtask

    task automatic unmapped_regs();
        read_reg(1, 8);
        read_reg(3, 63);
        // low bits of 8 and 15 alias registers 0 and 7 if decode is wrong
        write_reg(2, 8, 32'hdead_beef);
        write_reg(2, 15, 32'hfeed_f00d);
        for (int r = 0; r < NUM_REGS; r++) begin
            read_reg(2, r);
        end
    endtask

    task automatic clock_enable_gating();
        req.wr_clk_en = 1'b0;
        for (int t = 0; t < NUM_TILES; t++) begin
            write_reg(t, 3, 32'h0bad_0000 | t);
        end
        req.wr_clk_en = 1'b1;
        repeat (NUM_TILES) next_cycle();
        for (int t = 0; t < NUM_TILES; t++) begin
            read_reg(t, 3);
        end
        req.rd_clk_en = 1'b0;
        read_reg(2, 5);
        read_reg(0, 5);
        req.rd_clk_en = 1'b1;
        repeat (NUM_TILES) next_cycle();
    endtask

    task automatic write_priority();
        // same tile, the read is dropped
        access(1'b1, 1, 2, 32'h1234_5678, 1'b1, 1, 5);
        read_reg(1, 2);
        read_reg(1, 5);
        // different tiles, both go through
        access(1'b1, 3, 6, 32'h8765_4321, 1'b1, 0, 4);
        read_reg(3, 6);
    endtask

    task automatic random_traffic();
        int          tile;
        int          reg_num;
        logic [31:0] r;
        logic [31:0] data;
        seed = 32'ha995;
        for (int i = 0; i < 40; i++) begin
            r       = $random(seed);
            data    = $random(seed);
            tile    = int'(r[1:0]);
            reg_num = int'(r[5:2]) % 10;
            if (r[6]) begin
                read_reg(tile, reg_num);
            end else begin
                write_reg(tile, reg_num, data);
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        req           = '0;
        req.wr_clk_en = 1'b1;
        req.rd_clk_en = 1'b1;
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        model         = '{default: '0};
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;
        next_cycle();
        check_reset_state();
        write_read_back();
        unmapped_regs();
        clock_enable_gating();
        write_priority();
        random_traffic();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== glb_cfg_chain.f ====
hdl/glb_cfg_pkg.sv
hdl/glb_tile_cfg_regs.sv
hdl/glb_tile_cfg_ctrl.sv
hdl/glb_tile.sv
hdl/glb_cfg_chain.sv
tests/glb_cfg_chain_tb.sv

// ==== Makefile ====
SRCS := $(shell cat glb_cfg_chain.f)

.PHONY: run clean

run: obj_dir/Vglb_cfg_chain_tb
	@out=$$(./obj_dir/Vglb_cfg_chain_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

obj_dir/Vglb_cfg_chain_tb: glb_cfg_chain.f $(SRCS)
	verilator --binary --timing --assert --top-module glb_cfg_chain_tb -f glb_cfg_chain.f

clean:
	rm -rf obj_dir
